/* flist.f */
+incdir+verification
source/demodMapPkg.sv
source/demodSignalPkg.sv
source/miscRegs.sv
source/cycleTimer.sv
source/resetStretch.sv
source/symbolRouter.sv
source/dacChannel.sv
source/demodPassThru.sv
verification/tbDemodPassThru.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -f flist.f --top-module tbDemodPassThru -o simDemodPassThru

simOutput="$(./obj_dir/simDemodPassThru)"
echo "$simOutput"

if echo "$simOutput" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

/* source/cycleTimer.sv */
// Free-running cycle timer
`timescale 1ns/100ps
`default_nettype none

module cycleTimer (
    input  wire                 ck933,
    input  wire                 clockCounterEn,
    input  wire                 timerRestart,
    output demodMapPkg::regWord count
);

    // Restart zeroes the count at the strobe edge, then it wraps freely
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            count.whole <= '0;
        end else if (timerRestart) begin
            count.whole <= '0;
        end else begin
            count.whole <= count.whole + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/dacChannel.sv */
// DAC source select and slice
`timescale 1ns/100ps
`default_nettype none

module dacChannel (
    input  wire                                         ck933,
    input  wire  [demodSignalPkg::dacSelWidth-1:0]      dacSel,
    input  wire  [demodSignalPkg::sampleWidth-1:0]      demodSample,
    input  wire  [demodSignalPkg::sampleWidth-1:0]      pcmSample,
    input  wire  [demodSignalPkg::sampleWidth-1:0]      soqpskSample,
    input  wire  [demodSignalPkg::modeWidth-1:0]        mode,
    output logic [demodSignalPkg::dacWidth-1:0]         dac
);

    logic [demodSignalPkg::sampleWidth-1:0] selSample;

    // Stage one, pick the source
    always_ff @(posedge ck933) begin
        case (dacSel)
            demodSignalPkg::dacTrellisI,
            demodSignalPkg::dacTrellisQ,
            demodSignalPkg::dacTrellisPhErr,
            demodSignalPkg::dacTrellisIndex: begin
                selSample <= (mode == demodSignalPkg::modePcmTrellis) ?
                             pcmSample : soqpskSample;
            end
            default: begin
                selSample <= demodSample;
            end
        endcase
    end

    // Stage two, keep the top bits for the converter
    always_ff @(posedge ck933) begin
        dac <= selSample[demodSignalPkg::sampleWidth-1 -: demodSignalPkg::dacWidth];
    end

endmodule

`default_nettype wire

/* source/demodMapPkg.sv */
// Register map definitions
`default_nettype none

package demodMapPkg;

    // Bus geometry
    localparam int addrWidth = 12;
    localparam int busWidth = 16;

    // Miscellaneous space, 32 bytes
    localparam int miscSpaceBits = 5;
    localparam logic [addrWidth-1:0] miscBase = 12'h800;

    // Byte offsets of the 32-bit registers inside the space
    localparam logic [miscSpaceBits-1:0] regReset = 5'h00;
    localparam logic [miscSpaceBits-1:0] regVersion = 5'h04;
    localparam logic [miscSpaceBits-1:0] regClock = 5'h08;
    localparam logic [miscSpaceBits-1:0] regMode = 5'h0c;
    localparam logic [miscSpaceBits-1:0] regDacSel = 5'h10;

    // Returned in the high half
    localparam logic [busWidth-1:0] versionNumber = 16'h0120;

    // One register word, as a count or as two bus halves
    typedef union packed {
        logic [2*busWidth-1:0] whole;
        struct packed {
            logic [busWidth-1:0] high;
            logic [busWidth-1:0] low;
        } half;
    } regWord;

endpackage

`default_nettype wire

/* source/demodPassThru.sv */
// Demodulator pass-through top level
`timescale 1ns/100ps
`default_nettype none

module demodPassThru (
    input  wire                                     ck933,
    input  wire                                     clockCounterEn,
    input  wire                                     wrStrobe,
    input  wire                                     rdStrobe,
    input  wire  [demodMapPkg::addrWidth-1:0]       addr,
    input  wire  [demodMapPkg::busWidth-1:0]        wrData,
    output wire  [demodMapPkg::busWidth-1:0]        rdData,
    output wire                                     rdValid,
    input  wire                                     legacyIBit,
    input  wire                                     legacyQBit,
    input  wire                                     legacySymEn,
    input  wire                                     legacySym2xEn,
    input  wire                                     pcmBit,
    input  wire                                     pcmSymEn,
    input  wire                                     pcmSym2xEn,
    input  wire                                     soqpskBit,
    input  wire                                     soqpskSymEn,
    input  wire                                     soqpskSym2xEn,
    output wire                                     iData,
    output wire                                     qData,
    output wire                                     dataSymEn,
    output wire                                     dataSym2xEn,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  demodSample0,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  demodSample1,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  demodSample2,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  pcmSample0,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  pcmSample1,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  pcmSample2,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  soqpskSample0,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  soqpskSample1,
    input  wire  [demodSignalPkg::sampleWidth-1:0]  soqpskSample2,
    output wire  [demodSignalPkg::dacWidth-1:0]     dac0,
    output wire  [demodSignalPkg::dacWidth-1:0]     dac1,
    output wire  [demodSignalPkg::dacWidth-1:0]     dac2,
    output wire                                     demodReset
);

    wire [demodSignalPkg::modeWidth-1:0]    mode;
    wire [demodSignalPkg::dacSelWidth-1:0]  dacSel0;
    wire [demodSignalPkg::dacSelWidth-1:0]  dacSel1;
    wire [demodSignalPkg::dacSelWidth-1:0]  dacSel2;
    wire                                    timerRestart;
    wire                                    resetTrigger;
    demodMapPkg::regWord                    count;

    // ********************
    // Register space
    miscRegs regs (
        .ck933(ck933),
        .clockCounterEn(clockCounterEn),
        .wrStrobe(wrStrobe),
        .rdStrobe(rdStrobe),
        .addr(addr),
        .wrData(wrData),
        .rdData(rdData),
        .rdValid(rdValid),
        .mode(mode),
        .dacSel0(dacSel0),
        .dacSel1(dacSel1),
        .dacSel2(dacSel2),
        .timerRestart(timerRestart),
        .resetTrigger(resetTrigger),
        .count(count)
    );

    cycleTimer timer (
        .ck933(ck933),
        .clockCounterEn(clockCounterEn),
        .timerRestart(timerRestart),
        .count(count)
    );

    resetStretch stretch (
        .ck933(ck933),
        .clockCounterEn(clockCounterEn),
        .resetTrigger(resetTrigger),
        .demodReset(demodReset)
    );

    // ********************
    // Bit stream output
    symbolRouter router (
        .ck933(ck933),
        .clockCounterEn(clockCounterEn),
        .mode(mode),
        .legacyIBit(legacyIBit),
        .legacyQBit(legacyQBit),
        .legacySymEn(legacySymEn),
        .legacySym2xEn(legacySym2xEn),
        .pcmBit(pcmBit),
        .pcmSymEn(pcmSymEn),
        .pcmSym2xEn(pcmSym2xEn),
        .soqpskBit(soqpskBit),
        .soqpskSymEn(soqpskSymEn),
        .soqpskSym2xEn(soqpskSym2xEn),
        .iData(iData),
        .qData(qData),
        .dataSymEn(dataSymEn),
        .dataSym2xEn(dataSym2xEn)
    );

    // ********************
    // DAC outputs
    dacChannel dacCh0 (
        .ck933(ck933),
        .dacSel(dacSel0),
        .demodSample(demodSample0),
        .pcmSample(pcmSample0),
        .soqpskSample(soqpskSample0),
        .mode(mode),
        .dac(dac0)
    );

    dacChannel dacCh1 (
        .ck933(ck933),
        .dacSel(dacSel1),
        .demodSample(demodSample1),
        .pcmSample(pcmSample1),
        .soqpskSample(soqpskSample1),
        .mode(mode),
        .dac(dac1)
    );

    dacChannel dacCh2 (
        .ck933(ck933),
        .dacSel(dacSel2),
        .demodSample(demodSample2),
        .pcmSample(pcmSample2),
        .soqpskSample(soqpskSample2),
        .mode(mode),
        .dac(dac2)
    );

endmodule

`default_nettype wire

/* source/demodSignalPkg.sv */
// Demodulator signal definitions
`default_nettype none

package demodSignalPkg;

    // Demodulator modes
    localparam int modeWidth = 4;
    localparam logic [modeWidth-1:0] modeLegacy = 4'd0;
    localparam logic [modeWidth-1:0] modePcmTrellis = 4'd1;
    localparam logic [modeWidth-1:0] modeSoqpsk = 4'd2;
    // Routed like legacy here
    localparam logic [modeWidth-1:0] modeMultih = 4'd3;

    // DAC source selects, trellis group
    localparam int dacSelWidth = 4;
    localparam logic [dacSelWidth-1:0] dacTrellisI = 4'd8;
    localparam logic [dacSelWidth-1:0] dacTrellisQ = 4'd9;
    localparam logic [dacSelWidth-1:0] dacTrellisPhErr = 4'd10;
    localparam logic [dacSelWidth-1:0] dacTrellisIndex = 4'd11;

    // Sample and converter widths
    localparam int sampleWidth = 18;
    localparam int dacWidth = 14;

endpackage

`default_nettype wire

/* source/miscRegs.sv */
// Miscellaneous register block
`timescale 1ns/100ps
`default_nettype none

module miscRegs (
    input  wire                                         ck933,
    input  wire                                         clockCounterEn,
    input  wire                                         wrStrobe,
    input  wire                                         rdStrobe,
    input  wire  [demodMapPkg::addrWidth-1:0]           addr,
    input  wire  [demodMapPkg::busWidth-1:0]            wrData,
    output logic [demodMapPkg::busWidth-1:0]            rdData,
    output logic                                        rdValid,
    output logic [demodSignalPkg::modeWidth-1:0]        mode,
    output logic [demodSignalPkg::dacSelWidth-1:0]      dacSel0,
    output logic [demodSignalPkg::dacSelWidth-1:0]      dacSel1,
    output logic [demodSignalPkg::dacSelWidth-1:0]      dacSel2,
    output logic                                        timerRestart,
    output logic                                        resetTrigger,
    input  demodMapPkg::regWord                         count
);

    localparam int spaceBits = demodMapPkg::miscSpaceBits;
    localparam int selWidth = demodSignalPkg::dacSelWidth;

    logic                           miscHit;
    logic [spaceBits-1:0]           offset;
    logic                           wrHit;
    logic                           rdHit;
    logic                           timerSnap;
    demodMapPkg::regWord            hold;
    demodMapPkg::regWord            readWord;
    logic [demodMapPkg::busWidth-1:0] readHalf;

    // ********************
    // Address decode
    assign miscHit = (addr[demodMapPkg::addrWidth-1:spaceBits] ==
                      demodMapPkg::miscBase[demodMapPkg::addrWidth-1:spaceBits]);
    // Word offset, half select dropped
    assign offset = {addr[spaceBits-1:2], 2'b00};
    assign wrHit = wrStrobe & miscHit;
    assign rdHit = rdStrobe & miscHit;

    // Strobes to the timer and the reset stretcher
    assign timerRestart = wrHit & (offset == demodMapPkg::regClock);
    assign timerSnap = rdHit & (offset == demodMapPkg::regClock) & ~addr[1];
    assign resetTrigger = rdHit & (offset == demodMapPkg::regReset);

    // ********************
    // Writable registers
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            mode <= demodSignalPkg::modeLegacy;
            dacSel0 <= '0;
            dacSel1 <= '0;
            dacSel2 <= '0;
        end else if (wrHit) begin
            if (offset == demodMapPkg::regMode) begin
                mode <= wrData[demodSignalPkg::modeWidth-1:0];
            end
            if (offset == demodMapPkg::regDacSel) begin
                dacSel0 <= wrData[selWidth-1:0];
                dacSel1 <= wrData[2*selWidth-1:selWidth];
                dacSel2 <= wrData[3*selWidth-1:2*selWidth];
            end
        end
    end

    // Low half read freezes the count for the later high half read
    always_ff @(posedge ck933) begin
        if (timerSnap) begin
            hold <= count;
        end
    end

    // ********************
    // Read data
    always_comb begin
        readWord.whole = '0;
        if (miscHit) begin
            case (offset)
                demodMapPkg::regVersion: readWord.half.high = demodMapPkg::versionNumber;
                demodMapPkg::regClock: readWord = addr[1] ? hold : count;
                demodMapPkg::regMode: readWord.half.low[demodSignalPkg::modeWidth-1:0] = mode;
                demodMapPkg::regDacSel: readWord.half.low[3*selWidth-1:0] =
                    {dacSel2, dacSel1, dacSel0};
                default: readWord.whole = '0;
            endcase
        end
    end

    assign readHalf = addr[1] ? readWord.half.high : readWord.half.low;

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            rdData <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdStrobe;
            if (rdStrobe) begin
                rdData <= readHalf;
            end
        end
    end

endmodule

`default_nettype wire

/* source/resetStretch.sv */
// Downstream reset stretcher
`timescale 1ns/100ps
`default_nettype none

module resetStretch (
    input  wire  ck933,
    input  wire  clockCounterEn,
    input  wire  resetTrigger,
    output logic demodReset
);

    logic [2:0] stretchCount;

    // Load edge plus five more gives six cycles high
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            stretchCount <= '0;
            demodReset <= 1'b0;
        end else if (resetTrigger) begin
            stretchCount <= 3'd5;
            demodReset <= 1'b1;
        end else if (stretchCount != 3'd0) begin
            stretchCount <= stretchCount - 1'b1;
            demodReset <= 1'b1;
        end else begin
            demodReset <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/symbolRouter.sv */
// Output bit stream router
`timescale 1ns/100ps
`default_nettype none

module symbolRouter (
    input  wire                                     ck933,
    input  wire                                     clockCounterEn,
    input  wire  [demodSignalPkg::modeWidth-1:0]    mode,
    input  wire                                     legacyIBit,
    input  wire                                     legacyQBit,
    input  wire                                     legacySymEn,
    input  wire                                     legacySym2xEn,
    input  wire                                     pcmBit,
    input  wire                                     pcmSymEn,
    input  wire                                     pcmSym2xEn,
    input  wire                                     soqpskBit,
    input  wire                                     soqpskSymEn,
    input  wire                                     soqpskSym2xEn,
    output logic                                    iData,
    output logic                                    qData,
    output logic                                    dataSymEn,
    output logic                                    dataSym2xEn
);

    logic pcmMode;
    logic trellisMode;
    logic trellisBit;
    logic trellisSymEn;
    logic trellisSym2xEn;
    logic legacyI;
    logic legacyQ;
    logic legacyEn;
    logic legacy2xEn;

    assign pcmMode = (mode == demodSignalPkg::modePcmTrellis);
    assign trellisMode = pcmMode || (mode == demodSignalPkg::modeSoqpsk);

    // Enables, both stages
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisSymEn <= 1'b0;
            trellisSym2xEn <= 1'b0;
            legacyEn <= 1'b0;
            legacy2xEn <= 1'b0;
            dataSymEn <= 1'b0;
            dataSym2xEn <= 1'b0;
        end else begin
            trellisSymEn <= pcmMode ? pcmSymEn : soqpskSymEn;
            trellisSym2xEn <= pcmMode ? pcmSym2xEn : soqpskSym2xEn;
            legacyEn <= legacySymEn;
            legacy2xEn <= legacySym2xEn;
            dataSymEn <= trellisMode ? trellisSymEn : legacyEn;
            dataSym2xEn <= trellisMode ? trellisSym2xEn : legacy2xEn;
        end
    end

    // Data bits, same two stages
    always_ff @(posedge ck933) begin
        trellisBit <= pcmMode ? pcmBit : soqpskBit;
        legacyI <= legacyIBit;
        legacyQ <= legacyQBit;
        // Trellis decision feeds both I and Q
        iData <= trellisMode ? trellisBit : legacyI;
        qData <= trellisMode ? trellisBit : legacyQ;
    end

endmodule

`default_nettype wire

/* verification/tbModel.svh */
// Demodulator reference model
`ifndef tbModelSvh
`define tbModelSvh

// ********************
// Model state
int cycleCount = 0;
int writeEdge = 0;
int readEdge = 0;
int resetLeft = 0;
logic [demodSignalPkg::modeWidth-1:0] mMode;
logic [demodSignalPkg::dacSelWidth-1:0] mSel [3];

// Router stage one
logic trellisBitD;
logic trellisEnD;
logic trellis2xD;
logic legacyID;
logic legacyQD;
logic legacyEnD;
logic legacy2xD;

// Expected outputs after the latest edge
logic iExp;
logic qExp;
logic symEnExp;
logic sym2xExp;
logic rdValidExp;
logic [demodSignalPkg::sampleWidth-1:0] dacStage [3];
logic [demodSignalPkg::dacWidth-1:0] dacExp [3];

// ********************
// Decode and selection rules
function automatic logic inMisc(input logic [demodMapPkg::addrWidth-1:0] a);
    return a[11:5] == demodMapPkg::miscBase[11:5];
endfunction

function automatic logic [4:0] offsetOf(input logic [demodMapPkg::addrWidth-1:0] a);
    return {a[4:2], 2'b00};
endfunction

function automatic logic isTrellisMode(input logic [demodSignalPkg::modeWidth-1:0] m);
    return (m == demodSignalPkg::modePcmTrellis) || (m == demodSignalPkg::modeSoqpsk);
endfunction

// Trellis codes take the decoder of the current mode
function automatic logic [demodSignalPkg::sampleWidth-1:0] dacSource(
    input logic [demodSignalPkg::dacSelWidth-1:0] sel,
    input logic [demodSignalPkg::modeWidth-1:0] m,
    input logic [demodSignalPkg::sampleWidth-1:0] demod,
    input logic [demodSignalPkg::sampleWidth-1:0] pcm,
    input logic [demodSignalPkg::sampleWidth-1:0] soq
);
    if (sel inside {demodSignalPkg::dacTrellisI, demodSignalPkg::dacTrellisQ,
                    demodSignalPkg::dacTrellisPhErr, demodSignalPkg::dacTrellisIndex}) begin
        return (m == demodSignalPkg::modePcmTrellis) ? pcm : soq;
    end
    return demod;
endfunction

// ********************
// One clock edge of the DUT
task automatic modelStep();
    logic trellis;
    logic usePcm;
    int ch;
    cycleCount = cycleCount + 1;
    trellis = isTrellisMode(mMode);
    usePcm = (mMode == demodSignalPkg::modePcmTrellis);
    // Stage two sees the old stage one
    iExp = trellis ? trellisBitD : legacyID;
    qExp = trellis ? trellisBitD : legacyQD;
    symEnExp = trellis ? trellisEnD : legacyEnD;
    sym2xExp = trellis ? trellis2xD : legacy2xD;
    rdValidExp = rdStrobe;
    trellisBitD = usePcm ? pcmBit : soqpskBit;
    trellisEnD = usePcm ? pcmSymEn : soqpskSymEn;
    trellis2xD = usePcm ? pcmSym2xEn : soqpskSym2xEn;
    legacyID = legacyIBit;
    legacyQD = legacyQBit;
    legacyEnD = legacySymEn;
    legacy2xD = legacySym2xEn;
    for (ch = 0; ch < 3; ch++) begin
        dacExp[ch] = dacStage[ch][demodSignalPkg::sampleWidth-1 -: demodSignalPkg::dacWidth];
        dacStage[ch] = dacSource(mSel[ch], mMode, demodS[ch], pcmS[ch], soqS[ch]);
    end
    if (resetLeft != 0) begin
        resetLeft = resetLeft - 1;
    end
    if (clockCounterEn) begin
        mMode = demodSignalPkg::modeLegacy;
        for (ch = 0; ch < 3; ch++) begin
            mSel[ch] = '0;
        end
        trellisEnD = 1'b0;
        trellis2xD = 1'b0;
        legacyEnD = 1'b0;
        legacy2xD = 1'b0;
        symEnExp = 1'b0;
        sym2xExp = 1'b0;
        rdValidExp = 1'b0;
        resetLeft = 0;
    end else begin
        if (wrStrobe && inMisc(addr)) begin
            if (offsetOf(addr) == demodMapPkg::regMode) begin
                mMode = wrData[3:0];
            end
            if (offsetOf(addr) == demodMapPkg::regDacSel) begin
                mSel[0] = wrData[3:0];
                mSel[1] = wrData[7:4];
                mSel[2] = wrData[11:8];
            end
            if (offsetOf(addr) == demodMapPkg::regClock) begin
                writeEdge = cycleCount;
            end
        end
        if (rdStrobe && inMisc(addr)) begin
            // Six cycles high counting the trigger edge
            if (offsetOf(addr) == demodMapPkg::regReset) begin
                resetLeft = 6;
            end
            if (offsetOf(addr) == demodMapPkg::regClock && !addr[1]) begin
                readEdge = cycleCount;
            end
        end
    end
endtask

`endif

/* verification/tbDemodPassThru.sv */
// Demodulator pass-through testbench
`timescale 1ns/100ps
`default_nettype none

module tbDemodPassThru;

    localparam logic [31:0] randomSeed = 32'haa0841a0;
    localparam int regOps = 60;
    localparam int timerLoops = 8;
    localparam int maxGap = 40;
    // Low half read lands on 16'hffff
    localparam int wrapGap = 65534;
    localparam int streamCycles = 300;
    localparam int cycleLimit = 5 + 10 + regOps * 3 + timerLoops * (maxGap + 8)
                                + (wrapGap + 8) + 40 + 2 * (streamCycles + 2) + 100;

    logic ck933;
    logic clockCounterEn;
    logic wrStrobe;
    logic rdStrobe;
    logic [demodMapPkg::addrWidth-1:0] addr;
    logic [demodMapPkg::busWidth-1:0] wrData;
    logic legacyIBit;
    logic legacyQBit;
    logic legacySymEn;
    logic legacySym2xEn;
    logic pcmBit;
    logic pcmSymEn;
    logic pcmSym2xEn;
    logic soqpskBit;
    logic soqpskSymEn;
    logic soqpskSym2xEn;
    logic [demodSignalPkg::sampleWidth-1:0] demodS [3];
    logic [demodSignalPkg::sampleWidth-1:0] pcmS [3];
    logic [demodSignalPkg::sampleWidth-1:0] soqS [3];

    wire [demodMapPkg::busWidth-1:0] rdData;
    wire rdValid;
    wire iData;
    wire qData;
    wire dataSymEn;
    wire dataSym2xEn;
    wire [demodSignalPkg::dacWidth-1:0] dac0;
    wire [demodSignalPkg::dacWidth-1:0] dac1;
    wire [demodSignalPkg::dacWidth-1:0] dac2;
    wire demodReset;

    int errorCount = 0;
    int testCount = 0;
    int testErrorsStart = 0;
    logic checkOn = 1'b0;
    logic [31:0] rnd;
    demodMapPkg::regWord expWord;

`include "tbModel.svh"

    // ********************
    // Reporting
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("Test %0d (%s) finished with %0d errors", testCount, name,
                 errorCount - testErrorsStart);
        testErrorsStart = errorCount;
    endtask

    task automatic compareOutputs();
        checkValue("rdValid", 32'(rdValid), 32'(rdValidExp));
        checkValue("iData", 32'(iData), 32'(iExp));
        checkValue("qData", 32'(qData), 32'(qExp));
        checkValue("dataSymEn", 32'(dataSymEn), 32'(symEnExp));
        checkValue("dataSym2xEn", 32'(dataSym2xEn), 32'(sym2xExp));
        checkValue("demodReset", 32'(demodReset), 32'(resetLeft != 0));
        checkValue("dac0", 32'(dac0), 32'(dacExp[0]));
        checkValue("dac1", 32'(dac1), 32'(dacExp[1]));
        checkValue("dac2", 32'(dac2), 32'(dacExp[2]));
    endtask

    // ********************
    // Bus and stimulus helpers
    function automatic logic [demodMapPkg::addrWidth-1:0] regAddr(input logic [4:0] off,
                                                                  input logic high);
        return demodMapPkg::miscBase | {7'b0, off} | {10'b0, high, 1'b0};
    endfunction

    // Mostly the named modes and now and then any other code
    function automatic logic [demodSignalPkg::modeWidth-1:0] randomMode();
        logic [31:0] r;
        r = $urandom();
        if (r[7:5] == 3'd7) begin
            return r[3:0];
        end
        return {2'b00, r[1:0]};
    endfunction

    task automatic writeReg(input logic [demodMapPkg::addrWidth-1:0] a,
                            input logic [demodMapPkg::busWidth-1:0] d);
        @(negedge ck933);
        wrStrobe = 1'b1;
        addr = a;
        wrData = d;
        @(negedge ck933);
        wrStrobe = 1'b0;
    endtask

    task automatic readReg(input logic [demodMapPkg::addrWidth-1:0] a,
                           output logic [demodMapPkg::busWidth-1:0] d);
        int waitCount;
        waitCount = 0;
        @(negedge ck933);
        rdStrobe = 1'b1;
        addr = a;
        @(negedge ck933);
        rdStrobe = 1'b0;
        while (rdValid !== 1'b1 && waitCount < 4) begin
            @(negedge ck933);
            waitCount++;
        end
        if (rdValid !== 1'b1) begin
            errorCount++;
            $display("No rdValid came back for the read of address %h", a);
        end
        d = rdData;
    endtask

    task automatic readCheck(input string name, input logic [demodMapPkg::addrWidth-1:0] a,
                             input logic [31:0] expected);
        logic [demodMapPkg::busWidth-1:0] d;
        readReg(a, d);
        checkValue(name, 32'(d), expected);
    endtask

    // Restart, wait, then read both halves and compare with the cycle distance
    task automatic timerReadBack(input int gap);
        logic [demodMapPkg::busWidth-1:0] lo;
        logic [demodMapPkg::busWidth-1:0] hi;
        writeReg(regAddr(demodMapPkg::regClock, 1'b0), rnd[15:0]);
        repeat (gap) @(negedge ck933);
        readReg(regAddr(demodMapPkg::regClock, 1'b0), lo);
        readReg(regAddr(demodMapPkg::regClock, 1'b1), hi);
        expWord.whole = 32'(readEdge - writeEdge - 1);
        checkValue("timer low half", 32'(lo), 32'(expWord.half.low));
        checkValue("timer high half", 32'(hi), 32'(expWord.half.high));
    endtask

    task automatic countHigh(output int n);
        n = 0;
        while (demodReset === 1'b1 && n < 20) begin
            n++;
            @(negedge ck933);
        end
    endtask

    task automatic driveStreams();
        rnd = $urandom();
        {legacyIBit, legacyQBit, legacySymEn, legacySym2xEn, pcmBit, pcmSymEn,
         pcmSym2xEn, soqpskBit, soqpskSymEn, soqpskSym2xEn} = rnd[9:0];
    endtask

    task automatic driveSamples();
        int k;
        for (k = 0; k < 3; k++) begin
            rnd = $urandom();
            demodS[k] = rnd[17:0];
            rnd = $urandom();
            pcmS[k] = rnd[17:0];
            rnd = $urandom();
            soqS[k] = rnd[17:0];
        end
    endtask

    // ********************
    // DUT
    demodPassThru uut (
        .ck933(ck933),
        .clockCounterEn(clockCounterEn),
        .wrStrobe(wrStrobe),
        .rdStrobe(rdStrobe),
        .addr(addr),
        .wrData(wrData),
        .rdData(rdData),
        .rdValid(rdValid),
        .legacyIBit(legacyIBit),
        .legacyQBit(legacyQBit),
        .legacySymEn(legacySymEn),
        .legacySym2xEn(legacySym2xEn),
        .pcmBit(pcmBit),
        .pcmSymEn(pcmSymEn),
        .pcmSym2xEn(pcmSym2xEn),
        .soqpskBit(soqpskBit),
        .soqpskSymEn(soqpskSymEn),
        .soqpskSym2xEn(soqpskSym2xEn),
        .iData(iData),
        .qData(qData),
        .dataSymEn(dataSymEn),
        .dataSym2xEn(dataSym2xEn),
        .demodSample0(demodS[0]),
        .demodSample1(demodS[1]),
        .demodSample2(demodS[2]),
        .pcmSample0(pcmS[0]),
        .pcmSample1(pcmS[1]),
        .pcmSample2(pcmS[2]),
        .soqpskSample0(soqS[0]),
        .soqpskSample1(soqS[1]),
        .soqpskSample2(soqS[2]),
        .dac0(dac0),
        .dac1(dac1),
        .dac2(dac2),
        .demodReset(demodReset)
    );

    always #4 ck933 = ~ck933;

    // Model steps on each rising edge and outputs are compared on the falling edge
    always @(posedge ck933) begin
        modelStep();
    end

    always @(negedge ck933) begin
        if (checkOn) begin
            compareOutputs();
        end
    end

    always @(negedge ck933) begin
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    // ********************
    // Test sequence
    initial begin
        int i;
        int n;
        int gap;
        int unsigned seedDummy;
        logic [demodMapPkg::busWidth-1:0] lo;
        seedDummy = $urandom(randomSeed);
        ck933 = 1'b0;
        clockCounterEn = 1'b1;
        wrStrobe = 1'b0;
        rdStrobe = 1'b0;
        addr = '0;
        wrData = '0;
        {legacyIBit, legacyQBit, legacySymEn, legacySym2xEn, pcmBit, pcmSymEn,
         pcmSym2xEn, soqpskBit, soqpskSymEn, soqpskSym2xEn} = 10'b0;
        for (i = 0; i < 3; i++) begin
            demodS[i] = '0;
            pcmS[i] = '0;
            soqS[i] = '0;
        end
        repeat (5) @(negedge ck933);
        clockCounterEn = 1'b0;
        @(posedge ck933);
        checkOn = 1'b1;

        // Reset values
        @(negedge ck933);
        checkValue("rdValid", 32'(rdValid), 32'd0);
        checkValue("rdData", 32'(rdData), 32'd0);
        checkValue("demodReset", 32'(demodReset), 32'd0);
        checkValue("dataSymEn", 32'(dataSymEn), 32'd0);
        checkValue("dataSym2xEn", 32'(dataSym2xEn), 32'd0);
        readCheck("rdData mode", regAddr(demodMapPkg::regMode, 1'b0),
                  32'(demodSignalPkg::modeLegacy));
        readCheck("rdData version high", regAddr(demodMapPkg::regVersion, 1'b1),
                  32'(demodMapPkg::versionNumber));
        readCheck("rdData version low", regAddr(demodMapPkg::regVersion, 1'b0), 32'd0);
        endTest("reset values");

        // Random register traffic
        for (i = 0; i < regOps; i++) begin
            rnd = $urandom();
            case (rnd % 5)
                0: writeReg(regAddr(demodMapPkg::regMode, 1'b0), {12'b0, randomMode()});
                1: writeReg(regAddr(demodMapPkg::regDacSel, 1'b0), rnd[31:16]);
                2: readCheck("rdData mode", regAddr(demodMapPkg::regMode, 1'b0), 32'(mMode));
                3: readCheck("rdData dacSel", regAddr(demodMapPkg::regDacSel, 1'b0),
                             32'({mSel[2], mSel[1], mSel[0]}));
                default: begin
                    addr = rnd[27:16];
                    if (inMisc(addr)) begin
                        addr[11] = ~addr[11];
                    end
                    readCheck("rdData outside", addr, 32'd0);
                end
            endcase
        end
        endTest("register read back");

        // Timer restart and two-half read
        for (i = 0; i < timerLoops; i++) begin
            rnd = $urandom();
            timerReadBack(int'(rnd % (maxGap + 1)));
        end
        // Count crosses into the high half between the two reads
        timerReadBack(wrapGap);
        endTest("cycle timer");

        // Single and retriggered reset pulse
        readReg(regAddr(demodMapPkg::regReset, 1'b0), lo);
        countHigh(n);
        checkValue("demodReset high cycles", 32'(n), 32'd6);
        readReg(regAddr(demodMapPkg::regReset, 1'b0), lo);
        rnd = $urandom();
        gap = int'(rnd % 3);
        repeat (gap) @(negedge ck933);
        readReg(regAddr(demodMapPkg::regReset, 1'b0), lo);
        countHigh(n);
        checkValue("demodReset high cycles after retrigger", 32'(n), 32'd6);
        endTest("reset stretch");

        // Random streams under changing modes
        for (i = 0; i < streamCycles; i++) begin
            @(negedge ck933);
            driveStreams();
            wrStrobe = 1'b0;
            if (i % 8 == 0) begin
                wrStrobe = 1'b1;
                addr = regAddr(demodMapPkg::regMode, 1'b0);
                wrData = {12'b0, randomMode()};
            end
        end
        @(negedge ck933);
        wrStrobe = 1'b0;
        repeat (2) @(negedge ck933);
        endTest("symbol router");

        // Random samples, selects and modes
        for (i = 0; i < streamCycles; i++) begin
            @(negedge ck933);
            driveSamples();
            wrStrobe = 1'b0;
            rnd = $urandom();
            if (i % 6 == 0) begin
                wrStrobe = 1'b1;
                addr = regAddr(demodMapPkg::regDacSel, 1'b0);
                wrData = rnd[15:0];
            end else if (i % 6 == 3) begin
                wrStrobe = 1'b1;
                addr = regAddr(demodMapPkg::regMode, 1'b0);
                wrData = {12'b0, randomMode()};
            end
        end
        @(negedge ck933);
        wrStrobe = 1'b0;
        repeat (2) @(negedge ck933);
        endTest("DAC channels");

        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
